/* flist.f */
+incdir+hw
hw/pwm_pkg.sv
hw/mod_q_barrett.sv
hw/masked_mult_mod_q.sv
hw/pwm_delay_line.sv
hw/mask_prng.sv
hw/masked_pairwm.sv
hw/masked_pwm_top.sv
tests/masked_pwm_sva.sv
tests/masked_pwm_tb.sv

/* Bender.yml */
package:
  name: masked_pwm

sources:
  - include_dirs:
      - hw
    files:
      - hw/pwm_pkg.sv
      - hw/mod_q_barrett.sv
      - hw/masked_mult_mod_q.sv
      - hw/pwm_delay_line.sv
      - hw/mask_prng.sv
      - hw/masked_pairwm.sv
      - hw/masked_pwm_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/masked_pwm_sva.sv
      - tests/masked_pwm_tb.sv

/* tests/masked_pwm_tb.sv */
// table-driven testbench with unmasking reference model for the masked pairwise multiplier
`timescale 1ns/1ps
`include "pwm_config.svh"

module masked_pwm_tb;

    import pwm_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int DRIVE_DLY   = 1;
    localparam int RESET_CYC   = 4;
    localparam int N_VEC       = 12;
    // at most two cycles per beat, then the drain, then some slack
    localparam int PHASE_LIMIT = N_VEC * 2 + `PWM_PIPE_LAT + 20;

    typedef struct packed {
        coeff_t u0;
        coeff_t u1;
        coeff_t v0;
        coeff_t v1;
        coeff_t w0;
        coeff_t w1;
        coeff_t zeta;
        logic   acc;
        coeff_t exp0;
        coeff_t exp1;
    } vec_t;

    typedef struct packed {
        int     due;
        coeff_t res0;
        coeff_t res1;
    } expect_t;

    logic     clk = 1'b0;
    logic     reset_n;
    logic     zeroize;
    logic     in_valid;
    pwm_in_t  in_data;
    logic     out_valid;
    pwm_out_t out_data;

    vec_t    vecs [N_VEC];
    expect_t exp_q [$];
    expect_t got;
    int      cyc = 0;
    int      phase_start = 0;

    masked_pwm_top u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    bind masked_pwm_top masked_pwm_sva u_sva (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------------------------------------
    // reporting
    // --------------------------------------------------
    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("Error: time %0t signal %s got %0d expected %0d",
                                      $time, name, actual, expected));
        end
    endtask

    // --------------------------------------------------
    // reference model on unmasked values
    // --------------------------------------------------
    function automatic coeff_t model_res0(vec_t v);
        int t;
        t = (int'(v.u1) * int'(v.v1)) % `PWM_Q;
        t = (int'(v.u0) * int'(v.v0) + int'(v.zeta) * t) % `PWM_Q;
        if (v.acc) begin
            t = (t + int'(v.w0)) % `PWM_Q;
        end
        return coeff_t'(t);
    endfunction

    function automatic coeff_t model_res1(vec_t v);
        int t;
        t = (int'(v.u0) * int'(v.v1) + int'(v.u1) * int'(v.v0)) % `PWM_Q;
        if (v.acc) begin
            t = (t + int'(v.w1)) % `PWM_Q;
        end
        return coeff_t'(t);
    endfunction

    function automatic coeff_t unmask(share_t s);
        return coeff_t'((int'(s.s0) + int'(s.s1)) % `PWM_Q);
    endfunction

    // random first share and a second share that makes up the value
    function automatic share_t split_shares(coeff_t v);
        share_t s;
        int     r;
        r = $urandom % `PWM_Q;
        s.s0 = coeff_t'(r);
        s.s1 = coeff_t'((int'(v) + `PWM_Q - r) % `PWM_Q);
        return s;
    endfunction

    task automatic set_vec(input int idx, input int u0, u1, v0, v1, w0, w1, zeta,
                           input logic acc);
        vec_t v;
        v = '0;
        v.u0   = coeff_t'(u0);
        v.u1   = coeff_t'(u1);
        v.v0   = coeff_t'(v0);
        v.v1   = coeff_t'(v1);
        v.w0   = coeff_t'(w0);
        v.w1   = coeff_t'(w1);
        v.zeta = coeff_t'(zeta);
        v.acc  = acc;
        v.exp0 = model_res0(v);
        v.exp1 = model_res1(v);
        vecs[idx] = v;
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic drive_beat(input int idx);
        expect_t e;
        in_data.u0         = split_shares(vecs[idx].u0);
        in_data.u1         = split_shares(vecs[idx].u1);
        in_data.v0         = split_shares(vecs[idx].v0);
        in_data.v1         = split_shares(vecs[idx].v1);
        in_data.w0         = split_shares(vecs[idx].w0);
        in_data.w1         = split_shares(vecs[idx].w1);
        in_data.zeta       = split_shares(vecs[idx].zeta);
        in_data.accumulate = vecs[idx].acc;
        in_valid           = 1'b1;
        // captured on the next edge and visible PIPE_LAT edges later
        e.due  = cyc + `PWM_PIPE_LAT;
        e.res0 = vecs[idx].exp0;
        e.res1 = vecs[idx].exp1;
        exp_q.push_back(e);
    endtask

    task automatic drive_idle();
        in_valid = 1'b0;
        in_data  = '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        step_cycle();
    endtask

    task automatic start_phase();
        phase_start = cyc;
    endtask

    // cycle counter and watchdog
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc - phase_start > PHASE_LIMIT) begin
            stop_on_failure($sformatf("timeout: phase did not finish within %0d cycles",
                                      PHASE_LIMIT));
        end
    end

    // result monitor sampling outputs mid-cycle
    always @(negedge clk) begin
        if (reset_n) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    stop_on_failure("out_valid went high with no beat in flight");
                end else begin
                    got = exp_q.pop_front();
                    check_value("out_valid cycle", cyc, got.due);
                    check_value("out_data.res0", unmask(out_data.res0), got.res0);
                    check_value("out_data.res1", unmask(out_data.res1), got.res1);
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
                stop_on_failure("out_valid stayed low when a result was due");
            end
        end
    end

    // a failed concurrent assertion ends the run at once
    always @(negedge clk) begin
        if (u_dut.u_sva.fail_count != 0) begin
            stop_on_failure("a concurrent assertion in the bound checker failed");
        end
    end

    initial begin
        void'($urandom(58));
        reset_n  = 1'b0;
        zeroize  = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;

        //          idx  u0    u1    v0    v1    w0    w1    zeta  acc
        set_vec(0,   0,    0,    0,    0,    0,    0,    0,    1'b0);
        set_vec(1,   1,    1,    1,    1,    1,    1,    1,    1'b1);
        set_vec(2,   3328, 3328, 3328, 3328, 3328, 3328, 3328, 1'b0);
        set_vec(3,   3328, 1,    0,    3328, 5,    7,    17,   1'b1);
        set_vec(4,   1234, 2345, 3000, 17,   100,  200,  1729, 1'b0);
        set_vec(5,   17,   3328, 1,    2,    3327, 3328, 2580, 1'b1);
        set_vec(6,   2000, 2500, 3100, 3200, 1,    0,    3289, 1'b0);
        set_vec(7,   5,    6,    7,    8,    9,    10,   2642, 1'b1);
        set_vec(8,   3328, 0,    3328, 0,    1500, 1600, 1,    1'b0);
        set_vec(9,   0,    3328, 1,    3328, 3328, 1,    630,  1'b1);
        set_vec(10,  1111, 2222, 3327, 4,    2,    3,    1897, 1'b0);
        set_vec(11,  3000, 3100, 3200, 3300, 3328, 3328, 848,  1'b1);

        start_phase();
        repeat (RESET_CYC) @(posedge clk);
        #DRIVE_DLY;
        reset_n = 1'b1;
        @(negedge clk);
        check_value("out_valid", out_valid, 0);

        // whole table on consecutive cycles
        start_phase();
        for (int i = 0; i < N_VEC; i++) begin
            step_cycle();
            drive_beat(i);
        end
        step_cycle();
        drive_idle();
        wait_drain();

        // idle cycle after every second beat
        start_phase();
        for (int i = 0; i < N_VEC; i++) begin
            step_cycle();
            drive_beat(i);
            if (i % 2 == 1) begin
                step_cycle();
                drive_idle();
            end
        end
        step_cycle();
        drive_idle();
        wait_drain();

        // zeroize drops all four beats in flight
        start_phase();
        for (int i = 0; i < 4; i++) begin
            step_cycle();
            drive_beat(i + 4);
        end
        step_cycle();
        drive_idle();
        step_cycle();
        zeroize = 1'b1;
        exp_q.delete();
        step_cycle();
        zeroize = 1'b0;
        @(negedge clk);
        check_value("out_data", out_data, 0);
        check_value("out_valid", out_valid, 0);
        repeat (10) step_cycle();
        drive_beat(N_VEC - 1);
        step_cycle();
        drive_idle();
        wait_drain();

        repeat (2) step_cycle();
        if (u_dut.u_sva.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", u_dut.u_sva.fail_count);
            $display("Verification failed");
            $fatal(1, "simulation stopped");
        end
    end

endmodule

/* tests/masked_pwm_sva.sv */
// concurrent checks on pipeline latency, reset behavior and output share range
`timescale 1ns/1ps
`include "pwm_config.svh"

module masked_pwm_sva (
    input logic              clk,
    input logic              reset_n,
    input logic              zeroize,
    input logic              in_valid,
    input logic              out_valid,
    input pwm_pkg::pwm_out_t out_data
);

    import pwm_pkg::*;

    // cycles after the beat in which zeroize would drop it
    localparam int HOLD = `PWM_PIPE_LAT - 1;

    // count of failed assertions
    int unsigned fail_count = 0;

    // a beat untouched by zeroize leaves after exactly the pipeline latency
    property p_latency;
        @(posedge clk) disable iff (!reset_n)
            (in_valid && !zeroize) ##1 (!zeroize) [*HOLD] |=> out_valid;
    endproperty

    property p_quiet_in_reset;
        @(posedge clk) !reset_n |-> !out_valid;
    endproperty

    property p_share_range;
        @(posedge clk) disable iff (!reset_n)
            out_valid |-> (out_data.res0.s0 < `PWM_Q) && (out_data.res0.s1 < `PWM_Q) &&
                          (out_data.res1.s0 < `PWM_Q) && (out_data.res1.s1 < `PWM_Q);
    endproperty

    a_latency: assert property (p_latency)
        else begin
            fail_count++;
            $error("out_valid missing %0d cycles after in_valid", `PWM_PIPE_LAT);
        end

    a_quiet_in_reset: assert property (p_quiet_in_reset)
        else begin
            fail_count++;
            $error("out_valid high while reset is held");
        end

    a_share_range: assert property (p_share_range)
        else begin
            fail_count++;
            $error("output share not below q");
        end

endmodule

/* hw/masked_pwm_top.sv */
// top level, mask generator feeding the pairwise multiplier
`timescale 1ns/1ps

module masked_pwm_top (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize,
    input  logic              in_valid,
    input  pwm_pkg::pwm_in_t  in_data,
    output logic              out_valid,
    output pwm_pkg::pwm_out_t out_data
);

    import pwm_pkg::*;

    // fresh refresh values, one per multiplier
    pwm_rnd_t rnd;

    mask_prng u_prng (
        .clk     (clk),
        .reset_n (reset_n),
        .rnd     (rnd)
    );

    masked_pairwm u_pairwm (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .rnd       (rnd),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

/* hw/masked_pairwm.sv */
// masked pairwise multiply with optional accumulate, eight-cycle pipeline
`timescale 1ns/1ps
`include "pwm_config.svh"

module masked_pairwm (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize,
    input  logic              in_valid,
    input  pwm_pkg::pwm_in_t  in_data,
    input  pwm_pkg::pwm_rnd_t rnd,
    output logic              out_valid,
    output pwm_pkg::pwm_out_t out_data
);

    import pwm_pkg::*;

    // product, coefficient sum and accumulate stages
    localparam int SIDE_LAT = `PWM_PIPE_LAT - 1;

    share_t u0v0, u0v1, u1v0, zv1, u1zv1;
    share_t u1_d;
    share_t u0v0_d, u0v1_d, u1v0_d;
    share_t w0_d, w1_d;
    share_t w0_sel, w1_sel;
    share_t c0, c1;
    logic   acc_d;

    function automatic share_t add_share(share_t x, share_t y);
        share_t s;
        s.s0 = add_mod(x.s0, y.s0);
        s.s1 = add_mod(x.s1, y.s1);
        return s;
    endfunction

    // --------------------------------------------------
    // cycles 1-3 first products
    // --------------------------------------------------
    masked_mult_mod_q u_mul_u0v0 (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .a(in_data.u0), .b(in_data.v0), .r(rnd.r0), .z(u0v0)
    );

    masked_mult_mod_q u_mul_u0v1 (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .a(in_data.u0), .b(in_data.v1), .r(rnd.r1), .z(u0v1)
    );

    masked_mult_mod_q u_mul_u1v0 (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .a(in_data.u1), .b(in_data.v0), .r(rnd.r2), .z(u1v0)
    );

    masked_mult_mod_q u_mul_zv1 (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .a(in_data.zeta), .b(in_data.v1), .r(rnd.r3), .z(zv1)
    );

    // u1 waits for the reduced zeta*v1
    pwm_delay_line #(.T(share_t), .DEPTH(`PWM_MULT_LAT)) u_dly_u1 (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .d(in_data.u1), .q(u1_d)
    );

    // --------------------------------------------------
    // cycles 4-6 u1 * (zeta*v1)
    // --------------------------------------------------
    masked_mult_mod_q u_mul_u1zv1 (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .a(u1_d), .b(zv1), .r(rnd.r4), .z(u1zv1)
    );

    // first products held until the last one is ready
    pwm_delay_line #(.T(share_t), .DEPTH(`PWM_MULT_LAT)) u_dly_u0v0 (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .d(u0v0), .q(u0v0_d)
    );

    pwm_delay_line #(.T(share_t), .DEPTH(`PWM_MULT_LAT)) u_dly_u0v1 (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .d(u0v1), .q(u0v1_d)
    );

    pwm_delay_line #(.T(share_t), .DEPTH(`PWM_MULT_LAT)) u_dly_u1v0 (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .d(u1v0), .q(u1v0_d)
    );

    // side band: w pair and accumulate reach stage 8, valid leaves with the result
    pwm_delay_line #(.T(share_t), .DEPTH(SIDE_LAT)) u_dly_w0 (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .d(in_data.w0), .q(w0_d)
    );

    pwm_delay_line #(.T(share_t), .DEPTH(SIDE_LAT)) u_dly_w1 (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .d(in_data.w1), .q(w1_d)
    );

    pwm_delay_line #(.T(logic), .DEPTH(SIDE_LAT)) u_dly_acc (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .d(in_data.accumulate), .q(acc_d)
    );

    pwm_delay_line #(.T(logic), .DEPTH(`PWM_PIPE_LAT)) u_dly_valid (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .d(in_valid), .q(out_valid)
    );

    // --------------------------------------------------
    // cycles 7-8 sums and accumulate
    // --------------------------------------------------
    // zero shares when not accumulating
    assign w0_sel = acc_d ? w0_d : '0;
    assign w1_sel = acc_d ? w1_d : '0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            c0       <= '0;
            c1       <= '0;
            out_data <= '0;
        end else if (zeroize) begin
            c0       <= '0;
            c1       <= '0;
            out_data <= '0;
        end else begin
            c0            <= add_share(u0v0_d, u1zv1);
            c1            <= add_share(u0v1_d, u1v0_d);
            out_data.res0 <= add_share(c0, w0_sel);
            out_data.res1 <= add_share(c1, w1_sel);
        end
    end

endmodule

/* hw/mask_prng.sv */
// 64-bit LFSR giving five refresh coefficients below q each cycle
`timescale 1ns/1ps
`include "pwm_config.svh"

module mask_prng (
    input  logic              clk,
    input  logic              reset_n,
    output pwm_pkg::pwm_rnd_t rnd
);

    import pwm_pkg::*;

    logic [63:0] lfsr;
    logic        fb;

    // one subtraction is enough, a 12-bit field is below 2q
    function automatic coeff_t fold_q(logic [`PWM_COEFF_W-1:0] f);
        coeff_t res;
        res = f;
        if (f >= `PWM_Q) begin
            res = f - `PWM_Q;
        end
        return res;
    endfunction

    // x^64 + x^63 + x^61 + x^60 + 1
    assign fb = lfsr[63] ^ lfsr[62] ^ lfsr[60] ^ lfsr[59];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= `PWM_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[62:0], fb};
        end
    end

    always_comb begin
        rnd.r0 = fold_q(lfsr[11:0]);
        rnd.r1 = fold_q(lfsr[23:12]);
        rnd.r2 = fold_q(lfsr[35:24]);
        rnd.r3 = fold_q(lfsr[47:36]);
        rnd.r4 = fold_q(lfsr[59:48]);
    end

endmodule

/* hw/pwm_delay_line.sv */
// typed shift register with reset and zeroize
`timescale 1ns/1ps

module pwm_delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  T     d,
    output T     q
);

    T pipe [DEPTH];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else if (zeroize) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign q = pipe[DEPTH-1];

endmodule

/* hw/masked_mult_mod_q.sv */
// two-share masked multiplier modulo q with random refresh, three cycles
`timescale 1ns/1ps
`include "pwm_config.svh"

module masked_mult_mod_q (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             zeroize,
    input  pwm_pkg::share_t  a,
    input  pwm_pkg::share_t  b,
    input  pwm_pkg::coeff_t  r,
    output pwm_pkg::share_t  z
);

    import pwm_pkg::*;

    logic [`PWM_PROD_W-1:0] p0;
    logic [`PWM_PROD_W-1:0] p1;
    coeff_t                 y0;
    coeff_t                 y1;

    // --------------------------------------------------
    // product stage
    // --------------------------------------------------
    // each share of a meets both shares of b
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p0 <= '0;
            p1 <= '0;
        end else if (zeroize) begin
            p0 <= '0;
            p1 <= '0;
        end else begin
            p0 <= a.s0 * b.s0 + a.s0 * b.s1;
            p1 <= a.s1 * b.s0 + a.s1 * b.s1;
        end
    end

    // --------------------------------------------------
    // reduction, two cycles
    // --------------------------------------------------
    mod_q_barrett u_red0 (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x       (p0),
        .y       (y0)
    );

    mod_q_barrett u_red1 (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x       (p1),
        .y       (y1)
    );

    // refresh: +r on one share, -r on the other, sum unchanged
    assign z.s0 = add_mod(y0, r);
    assign z.s1 = sub_mod(y1, r);

endmodule

/* hw/mod_q_barrett.sv */
// two-stage pipelined Barrett reduction modulo q
`timescale 1ns/1ps
`include "pwm_config.svh"

module mod_q_barrett (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    input  logic [`PWM_PROD_W-1:0] x,
    output pwm_pkg::coeff_t        y
);

    // width of the Barrett constant and the quotient shift
    localparam int M_W   = 13;
    localparam int SHIFT = 2 * `PWM_COEFF_W;
    localparam int QH_W  = `PWM_PROD_W + M_W - SHIFT;

    localparam logic [M_W-1:0]         BARRETT_M = `PWM_BARRETT_M;
    localparam logic [`PWM_PROD_W-1:0] Q_FULL    = `PWM_Q;
    localparam logic [`PWM_COEFF_W:0]  Q_NARROW  = `PWM_Q;

    logic [`PWM_PROD_W+M_W-1:0] prod;
    logic [QH_W-1:0]            qhat;
    logic [QH_W-1:0]            qhat_r;
    logic [`PWM_PROD_W-1:0]     x_r;
    logic [`PWM_PROD_W-1:0]     diff;
    logic [`PWM_COEFF_W:0]      rem;
    logic [`PWM_COEFF_W:0]      rem_fix;

    // stage 1 quotient estimate
    assign prod = x * BARRETT_M;
    assign qhat = prod[`PWM_PROD_W+M_W-1:SHIFT];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            x_r    <= '0;
            qhat_r <= '0;
        end else if (zeroize) begin
            x_r    <= '0;
            qhat_r <= '0;
        end else begin
            x_r    <= x;
            qhat_r <= qhat;
        end
    end

    // stage 2
    // estimate is at most one short for x < 2*q*q, so rem < 2q fits 13 bits
    assign diff    = x_r - qhat_r * Q_FULL;
    assign rem     = diff[`PWM_COEFF_W:0];
    assign rem_fix = (rem >= Q_NARROW) ? rem - Q_NARROW : rem;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            y <= '0;
        end else if (zeroize) begin
            y <= '0;
        end else begin
            y <= rem_fix[`PWM_COEFF_W-1:0];
        end
    end

endmodule

/* hw/pwm_pkg.sv */
// share and payload types plus modular add and subtract helpers
`include "pwm_config.svh"

package pwm_pkg;

    // one coefficient, always kept below q
    typedef logic [`PWM_COEFF_W-1:0] coeff_t;

    // arithmetic sharing, value = (s0 + s1) mod q
    typedef struct packed {
        coeff_t s0;
        coeff_t s1;
    } share_t;

    typedef struct packed {
        share_t u0;
        share_t u1;
        share_t v0;
        share_t v1;
        share_t w0;
        share_t w1;
        share_t zeta;
        logic   accumulate;
    } pwm_in_t;

    typedef struct packed {
        share_t res0;
        share_t res1;
    } pwm_out_t;

    // one refresh value per masked multiplier
    typedef struct packed {
        coeff_t r0;
        coeff_t r1;
        coeff_t r2;
        coeff_t r3;
        coeff_t r4;
    } pwm_rnd_t;

    // --------------------------------------------------
    // modular helpers, operands below q
    // --------------------------------------------------
    function automatic coeff_t add_mod(coeff_t a, coeff_t b);
        logic [`PWM_COEFF_W:0] s;
        s = a + b;
        if (s >= `PWM_Q) begin
            s = s - `PWM_Q;
        end
        return s[`PWM_COEFF_W-1:0];
    endfunction

    function automatic coeff_t sub_mod(coeff_t a, coeff_t b);
        logic [`PWM_COEFF_W:0] d;
        d = {1'b0, a} - {1'b0, b};
        // wrap back into range on borrow
        if (a < b) begin
            d = d + `PWM_Q;
        end
        return d[`PWM_COEFF_W-1:0];
    endfunction

endpackage

/* hw/pwm_config.svh */
// modulus, widths, Barrett constant, latencies and LFSR seed of the masked multiplier
`ifndef PWM_CONFIG_SVH
`define PWM_CONFIG_SVH

// --------------------------------------------------
// arithmetic
// --------------------------------------------------
`define PWM_Q           3329
`define PWM_COEFF_W     12
// holds a0*b0 + a0*b1 with both factors below q
`define PWM_PROD_W      25
// floor(2^24 / q)
`define PWM_BARRETT_M   5039

// --------------------------------------------------
// pipeline timing
// --------------------------------------------------
`define PWM_MULT_LAT    3
`define PWM_PIPE_LAT    8

// --------------------------------------------------
// mask generator
// --------------------------------------------------
`define PWM_LFSR_SEED   64'h5A3C_96E1_0F7D_B248

`endif
